//--- compile.f
logic/trng_pkg.sv
logic/entropy_sampler.sv
logic/chunk_buffer.sv
logic/readout_port.sv
logic/trng_top.sv
testbench/trng_chk.sv
testbench/trng_tb.sv

//--- logic/chunk_buffer.sv
`timescale 1ns/1ps

module chunk_buffer #(
  parameter int CHUNK_WORDS = 16
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [trng_pkg::WORD_W-1:0]  word,
  input  logic                         word_valid,
  output logic                         word_ready,
  input  logic [trng_pkg::INDEX_W-1:0] rd_index,
  output logic [trng_pkg::WORD_W-1:0]  rd_word,
  input  logic                         chunk_release,
  output logic                         full
);

  localparam int PTR_W = $clog2(CHUNK_WORDS);

  // pointer wrap relies on a power-of-two depth
  if ((CHUNK_WORDS < 2) || (CHUNK_WORDS > 16) ||
      ((CHUNK_WORDS & (CHUNK_WORDS - 1)) != 0)) begin : g_bad_depth
    $error("chunk_buffer: CHUNK_WORDS must be a power of two from 2 to 16");
  end

  logic [trng_pkg::WORD_W-1:0] mem [CHUNK_WORDS];
  logic [PTR_W-1:0]            wr_ptr;
  logic [PTR_W-1:0]            wr_idx;
  logic                        store;

  //////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////

  assign word_ready = !full;
  assign store      = word_valid && word_ready;

  // a word landing together with release opens the next chunk
  assign wr_idx = chunk_release ? '0 : wr_ptr;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      full   <= 1'b0;
    end else if (chunk_release) begin
      wr_ptr <= store ? PTR_W'(1) : '0;
      full   <= 1'b0;
    end else if (store) begin
      wr_ptr <= wr_ptr + 1'b1;
      // last slot taken, hold the chunk
      if (wr_ptr == PTR_W'(CHUNK_WORDS - 1)) begin
        full <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (store) begin
      mem[wr_idx] <= word;
    end
  end

  //////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////

  // indices past the chunk read as zero
  assign rd_word = (int'(rd_index) < CHUNK_WORDS) ? mem[rd_index[PTR_W-1:0]] : '0;

endmodule

//--- logic/entropy_sampler.sv
`timescale 1ns/1ps

module entropy_sampler (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [trng_pkg::N_SOURCES-1:0] raw_bits,
  input  logic                           sample_valid,
  output logic                           sample_ready,
  input  logic [trng_pkg::MASK_W-1:0]    mask,
  output logic [trng_pkg::WORD_W-1:0]    word,
  output logic                           word_valid,
  input  logic                           word_ready
);

  localparam int CNT_W = $clog2(trng_pkg::WORD_W);

  logic [trng_pkg::WORD_W-1:0] shift_word;
  logic [trng_pkg::WORD_W-1:0] out_word;
  logic [trng_pkg::WORD_W-1:0] done_word;
  logic [CNT_W-1:0]            bit_cnt;
  logic                        shift_full;
  logic                        out_valid;
  logic                        sel_bit;
  logic                        sample_fire;
  logic                        last_bit;
  logic                        out_free;

  //////////////////////////////////////////////////
  // source selection
  //////////////////////////////////////////////////

  // xor of everything unless the mask names a single source
  always_comb begin
    sel_bit = ^raw_bits;
    for (int k = 1; k <= trng_pkg::N_SOURCES; k++) begin
      if (mask == trng_pkg::MASK_W'(k)) begin
        sel_bit = raw_bits[k-1];
      end
    end
  end

  //////////////////////////////////////////////////
  // handshakes
  //////////////////////////////////////////////////

  // stall only with both word slots taken
  assign sample_ready = !(shift_full && out_valid);
  assign sample_fire  = sample_valid && sample_ready;
  assign last_bit     = (bit_cnt == CNT_W'(trng_pkg::WORD_W - 1));

  // output slot can take a word this edge, also when it drains right now
  assign out_free = !out_valid || word_ready;

  // word completed by the bit arriving now
  assign done_word = {sel_bit, shift_word[trng_pkg::WORD_W-2:0]};

  assign word       = out_word;
  assign word_valid = out_valid;

  //////////////////////////////////////////////////
  // control state
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      bit_cnt    <= '0;
      shift_full <= 1'b0;
      out_valid  <= 1'b0;
    end else begin
      if (sample_fire) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
      if (shift_full && out_free) begin
        // parked word moves up, sampling resumes
        shift_full <= 1'b0;
        out_valid  <= 1'b1;
      end else if (sample_fire && last_bit) begin
        if (out_free) begin
          out_valid <= 1'b1;
        end else begin
          shift_full <= 1'b1;
        end
      end else if (out_free) begin
        out_valid <= 1'b0;
      end
    end
  end

  // word registers
  always_ff @(posedge clk) begin
    if (sample_fire) begin
      shift_word[bit_cnt] <= sel_bit;
    end
    if (shift_full && out_free) begin
      out_word <= shift_word;
    end else if (sample_fire && last_bit && out_free) begin
      out_word <= done_word;
    end
  end

endmodule

//--- logic/readout_port.sv
`timescale 1ns/1ps

module readout_port #(
  parameter int CHUNK_WORDS = 16
) (
  input  logic                         clk,
  input  logic                         reset,
  input  trng_pkg::host_addr_t         addr,
  input  logic                         rd,
  output logic [trng_pkg::WORD_W-1:0]  data_out,
  output logic [trng_pkg::INDEX_W-1:0] rd_index,
  input  logic [trng_pkg::WORD_W-1:0]  rd_word,
  output logic                         chunk_release,
  output logic [trng_pkg::MASK_W-1:0]  mask
);

  // every word of a chunk has to be reachable through the index field
  if (CHUNK_WORDS > (1 << trng_pkg::INDEX_W)) begin : g_index_reach
    $error("readout_port: CHUNK_WORDS exceeds the address index field");
  end

  logic data_rd;
  logic mask_wr;
  logic release_rd;

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////

  assign rd_index = addr.word_view.index;

  // data region, word index in the low bits
  assign data_rd = rd &&
                   (addr.word_view.region == trng_pkg::REGION_DATA) &&
                   (addr.word_view.unused == '0);

  // mask region, out-of-range values are dropped
  assign mask_wr = rd &&
                   (addr.ctrl_view.region == trng_pkg::REGION_MASK) &&
                   (addr.ctrl_view.unused == '0) &&
                   (addr.ctrl_view.mask_val <= trng_pkg::MASK_MAX);

  assign release_rd = rd && (addr == trng_pkg::ADDR_RELEASE);

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      data_out      <= '0;
      chunk_release <= 1'b0;
      mask          <= trng_pkg::MASK_XOR;
    end else begin
      // single-cycle pulse toward the buffer
      chunk_release <= release_rd;
      if (data_rd) begin
        data_out <= rd_word;
      end
      // new mask applies to the next accepted sample
      if (mask_wr) begin
        mask <= addr.ctrl_view.mask_val;
      end
    end
  end

endmodule

//--- logic/trng_pkg.sv
package trng_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int WORD_W    = 32;
  localparam int ADDR_W    = 11;
  localparam int N_SOURCES = 8;
  localparam int MASK_W    = 4;
  localparam int INDEX_W   = 4;
  localparam int REGION_W  = 3;

  //////////////////////////////////////////////////
  // host address map
  //////////////////////////////////////////////////

  // region code sits in address bits 10..8
  localparam logic [REGION_W-1:0] REGION_DATA = 3'd0;
  localparam logic [REGION_W-1:0] REGION_MASK = 3'd1;

  // full-address match, hands the chunk back for refill
  localparam logic [ADDR_W-1:0] ADDR_RELEASE = 11'h7FF;

  // mask encoding
  // 0 is the xor of all sources, k = 1..8 picks source k-1
  localparam logic [MASK_W-1:0] MASK_XOR = 4'd0;
  localparam logic [MASK_W-1:0] MASK_MAX = 4'd8;

  // one host address, read either as a data word index or as a mask value
  typedef union packed {
    struct packed {
      logic [REGION_W-1:0]               region;
      logic [ADDR_W-REGION_W-INDEX_W-1:0] unused;
      logic [INDEX_W-1:0]                index;
    } word_view;
    struct packed {
      logic [REGION_W-1:0]               region;
      logic [ADDR_W-REGION_W-MASK_W-1:0]  unused;
      logic [MASK_W-1:0]                 mask_val;
    } ctrl_view;
  } host_addr_t;

endpackage

//--- logic/trng_top.sv
`timescale 1ns/1ps

module trng_top #(
  parameter int CHUNK_WORDS = 16
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [trng_pkg::N_SOURCES-1:0] raw_bits,
  input  logic                           sample_valid,
  output logic                           sample_ready,
  input  trng_pkg::host_addr_t           addr,
  input  logic                           rd,
  output logic [trng_pkg::WORD_W-1:0]    data_out,
  output logic                           data_ready
);

  logic [trng_pkg::WORD_W-1:0]  word;
  logic                         word_valid;
  logic                         word_ready;
  logic [trng_pkg::INDEX_W-1:0] rd_index;
  logic [trng_pkg::WORD_W-1:0]  rd_word;
  logic                         chunk_release;
  logic                         full;
  logic [trng_pkg::MASK_W-1:0]  mask;

  // bit selection and word packing
  entropy_sampler u_sampler (
    .clk          (clk),
    .reset        (reset),
    .raw_bits     (raw_bits),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready),
    .mask         (mask),
    .word         (word),
    .word_valid   (word_valid),
    .word_ready   (word_ready)
  );

  // one chunk of words
  chunk_buffer #(.CHUNK_WORDS(CHUNK_WORDS)) u_buffer (
    .clk           (clk),
    .reset         (reset),
    .word          (word),
    .word_valid    (word_valid),
    .word_ready    (word_ready),
    .rd_index      (rd_index),
    .rd_word       (rd_word),
    .chunk_release (chunk_release),
    .full          (full)
  );

  // host side
  readout_port #(.CHUNK_WORDS(CHUNK_WORDS)) u_readout (
    .clk           (clk),
    .reset         (reset),
    .addr          (addr),
    .rd            (rd),
    .data_out      (data_out),
    .rd_index      (rd_index),
    .rd_word       (rd_word),
    .chunk_release (chunk_release),
    .mask          (mask)
  );

  assign data_ready = full;

endmodule

//--- testbench/trng_chk.sv
`timescale 1ns/1ps

module trng_chk (
  input logic                        clk,
  input logic                        reset,
  input logic                        rd,
  input logic [trng_pkg::ADDR_W-1:0] addr,
  input logic [trng_pkg::WORD_W-1:0] data_out,
  input logic                        data_ready
);

  int fail_count = 0;

  //////////////////////////////////////////////////
  // host port rules
  //////////////////////////////////////////////////

  // from the second reset cycle on, once the buffer has seen reset
  a_ready_in_reset: assert property (@(posedge clk) reset ##1 reset |-> !data_ready)
    else begin
      $error("data_ready high while reset is asserted");
      fail_count++;
    end

  a_out_after_rd: assert property (@(posedge clk) disable iff (reset)
    !$stable(data_out) |-> $past(rd))
    else begin
      $error("data_out changed without a read on the cycle before");
      fail_count++;
    end

  // release sampled, pulse registered, then full clears
  a_ready_fall: assert property (@(posedge clk) disable iff (reset)
    $fell(data_ready) |-> $past(rd && (addr == trng_pkg::ADDR_RELEASE), 2))
    else begin
      $error("data_ready fell without a release access");
      fail_count++;
    end

endmodule

bind trng_top trng_chk chk (
  .clk        (clk),
  .reset      (reset),
  .rd         (rd),
  .addr       (addr),
  .data_out   (data_out),
  .data_ready (data_ready)
);

//--- testbench/trng_tb.sv
`timescale 1ns/1ps

module trng_tb;

  localparam int CHUNK_WORDS = 8;
  localparam int N_CHUNKS    = 13;
  // about three cycles per host access
  localparam int HOST_CYCLES = 3 * ((1 << trng_pkg::INDEX_W) + 2);
  localparam int TIMEOUT     =
    N_CHUNKS * (CHUNK_WORDS * trng_pkg::WORD_W + HOST_CYCLES) * 4 + 10;

  localparam int MODE_IDLE   = 0;
  localparam int MODE_GAPS   = 1;
  localparam int MODE_STREAM = 2;

  logic                           clk          = 1'b0;
  logic                           reset        = 1'b1;
  logic [trng_pkg::N_SOURCES-1:0] raw_bits     = '0;
  logic                           sample_valid = 1'b0;
  logic                           sample_ready;
  trng_pkg::host_addr_t           addr         = '0;
  logic                           rd           = 1'b0;
  logic [trng_pkg::WORD_W-1:0]    data_out;
  logic                           data_ready;

  integer                         seed        = 32'hc19e_6697;
  int                             mode        = MODE_IDLE;
  int                             chunk       = 0;
  logic                           sample_wait = 1'b0;
  logic [trng_pkg::MASK_W-1:0]    mon_mask    = '0;
  logic [trng_pkg::N_SOURCES-1:0] raw_q[$];
  logic [trng_pkg::MASK_W-1:0]    mask_q[$];

  trng_top #(.CHUNK_WORDS(CHUNK_WORDS)) uut (
    .clk          (clk),
    .reset        (reset),
    .raw_bits     (raw_bits),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready),
    .addr         (addr),
    .rd           (rd),
    .data_out     (data_out),
    .data_ready   (data_ready)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // sample source and recorder
  //////////////////////////////////////////////////

  // a waiting sample keeps its bits until it is taken
  always @(posedge clk) begin
    if (!sample_wait) begin
      raw_bits <= $random(seed);
      case (mode)
        MODE_GAPS:   sample_valid <= ($random(seed) & 3) != 0;
        MODE_STREAM: sample_valid <= 1'b1;
        default:     sample_valid <= 1'b0;
      endcase
    end
  end

  // samples taken on the coming edge
  always @(negedge clk) begin
    if (reset) begin
      sample_wait = 1'b0;
    end else begin
      sample_wait = sample_valid && !sample_ready;
      if (sample_valid && sample_ready) begin
        raw_q.push_back(raw_bits);
        mask_q.push_back(mon_mask);
      end
    end
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic logic pick_bit(input logic [7:0] raw, input logic [3:0] m);
    if (m == 4'd0) begin
      return raw[0] ^ raw[1] ^ raw[2] ^ raw[3] ^ raw[4] ^ raw[5] ^ raw[6] ^ raw[7];
    end
    return raw[m - 1];
  endfunction

  // bit n of the word is sample first+n
  function automatic logic [31:0] expected_word(input int first);
    logic [31:0] w;
    for (int n = 0; n < 32; n++) begin
      w[n] = pick_bit(raw_q[first + n], mask_q[first + n]);
    end
    return w;
  endfunction

  function automatic trng_pkg::host_addr_t data_addr(input int idx);
    trng_pkg::host_addr_t a;
    a = '0;
    a.word_view.region = trng_pkg::REGION_DATA;
    a.word_view.index  = idx[trng_pkg::INDEX_W-1:0];
    return a;
  endfunction

  function automatic trng_pkg::host_addr_t mask_addr(input logic [3:0] val);
    trng_pkg::host_addr_t a;
    a = '0;
    a.ctrl_view.region   = trng_pkg::REGION_MASK;
    a.ctrl_view.mask_val = val;
    return a;
  endfunction

  //////////////////////////////////////////////////
  // host tasks and error reporting
  //////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("FAILED at %0t: %s expected 0x%h, actual 0x%h", $time, name, exp, act);
    $display(">>> FAIL");
    $fatal(1, "value mismatch");
  endtask

  task automatic set_mode(input int m);
    @(negedge clk);
    mode = m;
  endtask

  task automatic host_access(input trng_pkg::host_addr_t a);
    @(posedge clk);
    addr <= a;
    rd   <= 1'b1;
    @(posedge clk);
    rd   <= 1'b0;
  endtask

  task automatic read_check(input int idx, input logic [31:0] exp);
    host_access(data_addr(idx));
    @(negedge clk);
    assert (data_out == exp) else report_mismatch("data_out", exp, data_out);
  endtask

  task automatic write_mask(input logic [3:0] val);
    set_mode(MODE_IDLE);
    do @(negedge clk); while (sample_valid);
    host_access(mask_addr(val));
    // values past the last source leave the mask alone
    if (val <= trng_pkg::N_SOURCES) begin
      mon_mask = val;
    end
    set_mode(MODE_GAPS);
  endtask

  task automatic wait_chunk;
    int need;
    need = (chunk + 1) * CHUNK_WORDS * trng_pkg::WORD_W;
    do @(negedge clk); while (!data_ready);
    assert (raw_q.size() >= need)
      else abort_run("data_ready rose before a whole chunk of samples was taken");
  endtask

  task automatic check_chunk;
    int first;
    for (int w = 0; w < CHUNK_WORDS; w++) begin
      first = (chunk * CHUNK_WORDS + w) * trng_pkg::WORD_W;
      read_check(w, expected_word(first));
    end
    // indices past the chunk
    for (int w = CHUNK_WORDS; w < (1 << trng_pkg::INDEX_W); w++) begin
      read_check(w, '0);
    end
    host_access(trng_pkg::ADDR_RELEASE);
    @(negedge clk);
    assert (data_ready) else report_mismatch("data_ready", 1, data_ready);
    @(negedge clk);
    assert (!data_ready) else report_mismatch("data_ready", 0, data_ready);
    chunk++;
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    int stall_cycles;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    assert (!data_ready) else report_mismatch("data_ready", 0, data_ready);
    assert (data_out == '0) else report_mismatch("data_out", 0, data_out);
    assert (sample_ready) else report_mismatch("sample_ready", 1, sample_ready);

    // xor of all sources from the reset mask
    set_mode(MODE_GAPS);
    repeat (2) begin
      wait_chunk();
      check_chunk();
    end

    for (int k = 1; k <= trng_pkg::N_SOURCES; k++) begin
      write_mask(k);
      wait_chunk();
      check_chunk();
    end

    // value above 8 leaves source 7 selected
    write_mask(4'd12);
    wait_chunk();
    check_chunk();

    // chunk held unread with samples offered every cycle
    set_mode(MODE_STREAM);
    wait_chunk();
    stall_cycles = 0;
    while (sample_ready && (stall_cycles < 4 * trng_pkg::WORD_W)) begin
      @(negedge clk);
      stall_cycles++;
    end
    assert (!sample_ready)
      else abort_run("sample_ready stayed high while the full chunk was held");
    check_chunk();
    wait_chunk();
    check_chunk();

    set_mode(MODE_IDLE);
    repeat (4) @(negedge clk);
    if (uut.chk.fail_count == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      abort_run("the bound checker reported protocol errors");
    end
  end

  initial begin
    repeat (TIMEOUT) @(posedge clk);
    abort_run("timeout: the tests did not finish in the allowed number of cycles");
  end

endmodule
